/* rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Data path and address width
`define RV_XLEN        32

// Integer register file size, x0 included
`define RV_NUM_REGS    32
`define RV_REG_ADDR_W  5

// Sequential fetch increment in bytes
`define RV_PC_STEP     4

//////////////////////////////////////////////////
// Major opcodes of the kept instruction groups
//////////////////////////////////////////////////

// Register-register ALU ops
`define RV_OPC_OP      7'b0110011
// Register-immediate ALU ops
`define RV_OPC_OP_IMM  7'b0010011
`define RV_OPC_LUI     7'b0110111
// Only SW is decoded here
`define RV_OPC_STORE   7'b0100011

`endif

/* rv_pkg.sv */
package rv_pkg;

`include "rv_params.svh"

  //////////////////////////////////////////////////
  // Instruction formats
  //////////////////////////////////////////////////

  // R-type, register-register
  typedef struct packed {
    logic [6:0]                funct7;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [2:0]                funct3;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [6:0]                opcode;
  } instr_r_t;

  // I-type, 12 bit signed immediate
  typedef struct packed {
    logic [11:0]               imm;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [2:0]                funct3;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [6:0]                opcode;
  } instr_i_t;

  // S-type, offset split around rs2/rs1
  typedef struct packed {
    logic [6:0]                imm_hi;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [2:0]                funct3;
    logic [4:0]                imm_lo;
    logic [6:0]                opcode;
  } instr_s_t;

  // U-type, upper 20 bits
  typedef struct packed {
    logic [19:0]               imm;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [6:0]                opcode;
  } instr_u_t;

  // One fetched word, four views
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
    instr_s_t s;
    instr_u_t u;
  } instr_u;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_op_e;

  //////////////////////////////////////////////////
  // Pipeline payloads
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    instr_u              instr;
  } if_id_pipe_t;

  typedef struct packed {
    logic                      valid;
    alu_op_e                   alu_op;
    logic [`RV_XLEN-1:0]       op_a;
    logic [`RV_XLEN-1:0]       op_b;
    logic [`RV_XLEN-1:0]       st_data;
    logic                      rf_we;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic                      store;
    logic [11:0]               st_offset;
  } id_ex_pipe_t;

  // Writeback port, also the forwarding source
  typedef struct packed {
    logic                      we;
    logic [`RV_REG_ADDR_W-1:0] addr;
    logic [`RV_XLEN-1:0]       data;
  } rf_wb_t;

endpackage

/* rv_register_file.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_register_file import rv_pkg::*; (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic [`RV_REG_ADDR_W-1:0] raddr_a_i,
  input  logic [`RV_REG_ADDR_W-1:0] raddr_b_i,
  output logic [`RV_XLEN-1:0]       rdata_a_o,
  output logic [`RV_XLEN-1:0]       rdata_b_o,
  input  rf_wb_t                    wb_i
);

  // x1..x31 only, x0 has no storage
  logic [`RV_XLEN-1:0] regs_q [1:`RV_NUM_REGS-1];

  // Single write port, writes to x0 dropped
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb_i.we && (wb_i.addr != '0)) begin
      regs_q[wb_i.addr] <= wb_i.data;
    end
  end

  // Combinational reads, x0 reads as zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* rv_if_stage.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_if_stage import rv_pkg::*; (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                fetch_enable_i,
  input  logic [`RV_XLEN-1:0] boot_addr_i,
  output logic                instr_req_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  output logic [`RV_XLEN-1:0] instr_addr_o,
  input  instr_u              instr_rdata_i,
  input  logic                stall_i,
  input  logic                id_busy_i,
  output if_id_pipe_t         if_id_pipe_o,
  output logic                core_sleep_o
);

  // Set one cycle after reset, PC loaded from boot address then
  logic                booted_q;
  logic [`RV_XLEN-1:0] pc_q;
  // Address of the request in flight
  logic [`RV_XLEN-1:0] fetch_pc_q;
  logic                outstanding_q;
  logic                accept;
  // IF/ID register free or drained this cycle
  logic                can_load;
  logic                rvalid;
  if_id_pipe_t         fetched;
  if_id_pipe_t         pipe_q;
  // One-entry skid for a word returned under stall
  if_id_pipe_t         hold_q;

  assign can_load = !stall_i || !pipe_q.valid;
  assign rvalid   = instr_rvalid_i && outstanding_q;
  assign fetched  = {1'b1, fetch_pc_q, instr_rdata_i};

  // Next request may overlap the response cycle if the word has a place
  assign instr_req_o  = booted_q && fetch_enable_i && !hold_q.valid &&
                        (!outstanding_q || (rvalid && can_load));
  assign instr_addr_o = pc_q;
  assign accept       = instr_req_o && instr_gnt_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      booted_q      <= 1'b0;
      pc_q          <= '0;
      fetch_pc_q    <= '0;
      outstanding_q <= 1'b0;
    end else begin
      booted_q <= 1'b1;
      // No branches, PC only steps forward
      if (!booted_q) begin
        pc_q <= boot_addr_i;
      end else if (accept) begin
        pc_q <= pc_q + `RV_XLEN'(`RV_PC_STEP);
      end
      if (accept) begin
        fetch_pc_q    <= pc_q;
        outstanding_q <= 1'b1;
      end else if (rvalid) begin
        outstanding_q <= 1'b0;
      end
    end
  end

  // IF/ID register and skid
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pipe_q <= '0;
      hold_q <= '0;
    end else if (can_load) begin
      // Held word first, it is older
      if (hold_q.valid) begin
        pipe_q       <= hold_q;
        hold_q.valid <= 1'b0;
      end else if (rvalid) begin
        pipe_q <= fetched;
      end else begin
        pipe_q.valid <= 1'b0;
      end
    end else if (rvalid) begin
      hold_q <= fetched;
    end
  end

  assign if_id_pipe_o = pipe_q;

  // Idle only once every stage has drained
  assign core_sleep_o = !fetch_enable_i && !outstanding_q && !pipe_q.valid &&
                        !hold_q.valid && !id_busy_i;

endmodule

/* rv_id_stage.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_id_stage import rv_pkg::*; (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  if_id_pipe_t               if_id_pipe_i,
  input  logic                      stall_i,
  output logic [`RV_REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [`RV_REG_ADDR_W-1:0] rf_raddr_b_o,
  input  logic [`RV_XLEN-1:0]       rf_rdata_a_i,
  input  logic [`RV_XLEN-1:0]       rf_rdata_b_i,
  input  rf_wb_t                    rf_wb_i,
  output id_ex_pipe_t               id_ex_pipe_o
);

  instr_u              instr;
  logic [2:0]          funct3;
  // funct7 patterns, also imm[11:5] of shift immediates
  logic                f7_zero;
  logic                f7_alt;
  logic [`RV_XLEN-1:0] opnd_a;
  logic [`RV_XLEN-1:0] opnd_b;
  logic [`RV_XLEN-1:0] imm_i;
  logic [11:0]         imm_s;
  logic [`RV_XLEN-1:0] imm_u;
  id_ex_pipe_t         id_ex_d;
  id_ex_pipe_t         id_ex_q;

  // funct3 to ALU op, alt selects SUB or SRA
  function automatic alu_op_e dec_alu(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign instr   = if_id_pipe_i.instr;
  assign funct3  = instr.r.funct3;
  assign f7_zero = (instr.r.funct7 == 7'b0000000);
  assign f7_alt  = (instr.r.funct7 == 7'b0100000);

  // Same rs fields in R, I and S views
  assign rf_raddr_a_o = instr.r.rs1;
  assign rf_raddr_b_o = instr.r.rs2;

  // Bypass the result leaving EX this cycle
  assign opnd_a = (rf_wb_i.we && (rf_wb_i.addr != '0) && (rf_wb_i.addr == instr.r.rs1)) ?
                  rf_wb_i.data : rf_rdata_a_i;
  assign opnd_b = (rf_wb_i.we && (rf_wb_i.addr != '0) && (rf_wb_i.addr == instr.r.rs2)) ?
                  rf_wb_i.data : rf_rdata_b_i;

  // Immediates
  assign imm_i = {{(`RV_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
  assign imm_s = {instr.s.imm_hi, instr.s.imm_lo};
  assign imm_u = {instr.u.imm, 12'b0};

  always_comb begin
    id_ex_d         = '0;
    id_ex_d.valid   = if_id_pipe_i.valid;
    id_ex_d.alu_op  = ALU_ADD;
    id_ex_d.op_a    = opnd_a;
    id_ex_d.op_b    = opnd_b;
    id_ex_d.st_data = opnd_b;
    id_ex_d.rd      = instr.r.rd;
    // Anything not matched below has no effect
    if (if_id_pipe_i.valid) begin
      case (instr.r.opcode)
        `RV_OPC_OP: begin
          id_ex_d.alu_op = dec_alu(funct3, f7_alt);
          id_ex_d.rf_we  = f7_zero || (f7_alt && ((funct3 == 3'b000) || (funct3 == 3'b101)));
        end
        `RV_OPC_OP_IMM: begin
          // ADDI with imm[10] set is not SUB
          id_ex_d.alu_op = dec_alu(funct3, f7_alt && (funct3 == 3'b101));
          id_ex_d.op_b   = imm_i;
          case (funct3)
            3'b001:  id_ex_d.rf_we = f7_zero;
            3'b101:  id_ex_d.rf_we = f7_zero || f7_alt;
            default: id_ex_d.rf_we = 1'b1;
          endcase
        end
        `RV_OPC_LUI: begin
          id_ex_d.op_a  = '0;
          id_ex_d.op_b  = imm_u;
          id_ex_d.rf_we = 1'b1;
        end
        `RV_OPC_STORE: begin
          // SW only
          id_ex_d.store     = (funct3 == 3'b010);
          id_ex_d.st_offset = imm_s;
        end
        default: begin
          id_ex_d.rf_we = 1'b0;
        end
      endcase
    end
  end

  // ID/EX register, frozen under store stall
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      id_ex_q <= '0;
    end else if (!stall_i) begin
      id_ex_q <= id_ex_d;
    end
  end

  assign id_ex_pipe_o = id_ex_q;

endmodule

/* rv_ex_stage.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_ex_stage import rv_pkg::*; (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  id_ex_pipe_t         id_ex_pipe_i,
  output rf_wb_t              rf_wb_o,
  output logic                stall_o,
  output logic                data_req_o,
  input  logic                data_gnt_i,
  output logic [`RV_XLEN-1:0] data_addr_o,
  output logic [`RV_XLEN-1:0] data_wdata_o
);

  localparam int SHAMT_W = $clog2(`RV_XLEN);

  logic [SHAMT_W-1:0]  shamt;
  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] st_addr;
  // Store waiting for grant since an earlier cycle
  logic                st_wait_q;
  logic [`RV_XLEN-1:0] st_addr_q;
  logic [`RV_XLEN-1:0] st_wdata_q;

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////

  // Low five bits only
  assign shamt = id_ex_pipe_i.op_b[SHAMT_W-1:0];

  always_comb begin
    case (id_ex_pipe_i.alu_op)
      ALU_SUB:  alu_result = id_ex_pipe_i.op_a - id_ex_pipe_i.op_b;
      ALU_AND:  alu_result = id_ex_pipe_i.op_a & id_ex_pipe_i.op_b;
      ALU_OR:   alu_result = id_ex_pipe_i.op_a | id_ex_pipe_i.op_b;
      ALU_XOR:  alu_result = id_ex_pipe_i.op_a ^ id_ex_pipe_i.op_b;
      ALU_SLL:  alu_result = id_ex_pipe_i.op_a << shamt;
      ALU_SRL:  alu_result = id_ex_pipe_i.op_a >> shamt;
      ALU_SRA:  alu_result = $signed(id_ex_pipe_i.op_a) >>> shamt;
      // Set-less-than, signed then unsigned
      ALU_SLT:  alu_result = {{(`RV_XLEN-1){1'b0}},
                              $signed(id_ex_pipe_i.op_a) < $signed(id_ex_pipe_i.op_b)};
      ALU_SLTU: alu_result = {{(`RV_XLEN-1){1'b0}}, id_ex_pipe_i.op_a < id_ex_pipe_i.op_b};
      default:  alu_result = id_ex_pipe_i.op_a + id_ex_pipe_i.op_b;
    endcase
  end

  // Writeback on the edge closing this cycle, also fed back to ID
  always_comb begin
    rf_wb_o.we   = id_ex_pipe_i.valid && id_ex_pipe_i.rf_we;
    rf_wb_o.addr = id_ex_pipe_i.rd;
    rf_wb_o.data = alu_result;
  end

  //////////////////////////////////////////////////
  // Store issue
  //////////////////////////////////////////////////

  // rs1 plus sign-extended offset
  assign st_addr = id_ex_pipe_i.op_a +
                   {{(`RV_XLEN-12){id_ex_pipe_i.st_offset[11]}}, id_ex_pipe_i.st_offset};

  assign data_req_o = id_ex_pipe_i.valid && id_ex_pipe_i.store;
  assign stall_o    = data_req_o && !data_gnt_i;

  // Bus payload from local flops after the first wait cycle
  assign data_addr_o  = st_wait_q ? st_addr_q : st_addr;
  assign data_wdata_o = st_wait_q ? st_wdata_q : id_ex_pipe_i.st_data;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      st_wait_q  <= 1'b0;
      st_addr_q  <= '0;
      st_wdata_q <= '0;
    end else begin
      st_wait_q <= stall_o;
      // Capture once, on entry to the wait
      if (stall_o && !st_wait_q) begin
        st_addr_q  <= st_addr;
        st_wdata_q <= id_ex_pipe_i.st_data;
      end
    end
  end

endmodule

/* rv_core.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_core import rv_pkg::*; (
  input  logic                clk_i,
  input  logic                arst_n_i,

  // Fetch control and status
  input  logic                fetch_enable_i,
  input  logic [`RV_XLEN-1:0] boot_addr_i,
  output logic                core_sleep_o,

  // Instruction bus
  output logic                instr_req_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  output logic [`RV_XLEN-1:0] instr_addr_o,
  input  instr_u              instr_rdata_i,

  // Data bus, stores only
  output logic                data_req_o,
  input  logic                data_gnt_i,
  output logic [`RV_XLEN-1:0] data_addr_o,
  output logic [`RV_XLEN-1:0] data_wdata_o
);

  // Stage to stage payloads
  if_id_pipe_t               if_id_pipe;
  id_ex_pipe_t               id_ex_pipe;
  rf_wb_t                    rf_wb;

  // Store back-pressure from EX
  logic                      stall;

  // Register file read ports
  logic [`RV_REG_ADDR_W-1:0] rf_raddr_a;
  logic [`RV_REG_ADDR_W-1:0] rf_raddr_b;
  logic [`RV_XLEN-1:0]       rf_rdata_a;
  logic [`RV_XLEN-1:0]       rf_rdata_b;

  //////////////////////////////////////////////////
  // Fetch
  //////////////////////////////////////////////////

  rv_if_stage if_stage_i (
    .clk_i          ( clk_i            ),
    .arst_n_i       ( arst_n_i         ),
    .fetch_enable_i ( fetch_enable_i   ),
    .boot_addr_i    ( boot_addr_i      ),
    .instr_req_o    ( instr_req_o      ),
    .instr_gnt_i    ( instr_gnt_i      ),
    .instr_rvalid_i ( instr_rvalid_i   ),
    .instr_addr_o   ( instr_addr_o     ),
    .instr_rdata_i  ( instr_rdata_i    ),
    .stall_i        ( stall            ),
    // EX occupancy for the sleep status
    .id_busy_i      ( id_ex_pipe.valid ),
    .if_id_pipe_o   ( if_id_pipe       ),
    .core_sleep_o   ( core_sleep_o     )
  );

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  rv_id_stage id_stage_i (
    .clk_i          ( clk_i            ),
    .arst_n_i       ( arst_n_i         ),
    .if_id_pipe_i   ( if_id_pipe       ),
    .stall_i        ( stall            ),
    .rf_raddr_a_o   ( rf_raddr_a       ),
    .rf_raddr_b_o   ( rf_raddr_b       ),
    .rf_rdata_a_i   ( rf_rdata_a       ),
    .rf_rdata_b_i   ( rf_rdata_b       ),
    .rf_wb_i        ( rf_wb            ),
    .id_ex_pipe_o   ( id_ex_pipe       )
  );

  //////////////////////////////////////////////////
  // Execute and writeback
  //////////////////////////////////////////////////

  rv_ex_stage ex_stage_i (
    .clk_i          ( clk_i            ),
    .arst_n_i       ( arst_n_i         ),
    .id_ex_pipe_i   ( id_ex_pipe       ),
    .rf_wb_o        ( rf_wb            ),
    .stall_o        ( stall            ),
    .data_req_o     ( data_req_o       ),
    .data_gnt_i     ( data_gnt_i       ),
    .data_addr_o    ( data_addr_o      ),
    .data_wdata_o   ( data_wdata_o     )
  );

  rv_register_file register_file_i (
    .clk_i          ( clk_i            ),
    .arst_n_i       ( arst_n_i         ),
    .raddr_a_i      ( rf_raddr_a       ),
    .raddr_b_i      ( rf_raddr_b       ),
    .rdata_a_o      ( rf_rdata_a       ),
    .rdata_b_o      ( rf_rdata_b       ),
    .wb_i           ( rf_wb            )
  );

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module tb_checker #(
  parameter int PROG_LEN   = 200,
  parameter int PREFIX_LEN = 8
) (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        fetch_enable_i,
  input  logic [31:0] boot_addr_i,
  input  logic        instr_req_i,
  input  logic        instr_gnt_i,
  input  logic [31:0] instr_addr_i,
  input  logic        data_req_i,
  input  logic        data_gnt_i,
  input  logic [31:0] data_addr_i,
  input  logic [31:0] data_wdata_i,
  input  logic        core_sleep_i,
  input  logic [31:0] prog_i [PROG_LEN],
  output logic        done_o,
  output int          error_cnt_o
);

  // Architectural state of the reference model
  logic [31:0] regs [32];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int          exp_idx [$];
  int          exp_total;
  logic [31:0] exp_pc;
  logic        model_ready;
  // Per test: reset, fetch, stores, forwarding, order, sleep
  int          chk [6];
  int          err [6];
  logic        en_seen;
  logic        slept;
  int          off_cycles;
  int          store_cnt;
  int          t;

  // RV32I integer ops by funct3, alt picks SUB and SRA
  function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic exec_word(input logic [31:0] w, input int idx);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        we;
    a   = regs[w[19:15]];
    b   = regs[w[24:20]];
    res = 32'h0;
    we  = 1'b0;
    case (w[6:0])
      `RV_OPC_OP: begin
        res = alu_result(w[14:12], w[30], a, b);
        we  = 1'b1;
      end
      `RV_OPC_OP_IMM: begin
        res = alu_result(w[14:12], w[30] && (w[14:12] == 3'd5), a, {{20{w[31]}}, w[31:20]});
        we  = 1'b1;
      end
      `RV_OPC_LUI: begin
        res = {w[31:12], 12'h000};
        we  = 1'b1;
      end
      `RV_OPC_STORE: begin
        if (w[14:12] == 3'b010) begin
          exp_addr.push_back(a + {{20{w[31]}}, w[31:25], w[11:7]});
          exp_data.push_back(b);
          exp_idx.push_back(idx);
        end
      end
      default: begin
      end
    endcase
    if (we && w[11:7] != 5'd0) begin
      regs[w[11:7]] = res;
    end
  endtask

  task automatic compare(input int tn, input string name, input logic [31:0] got,
                         input logic [31:0] exp);
    chk[tn]++;
    if (got !== exp) begin
      err[tn]++;
      $display("Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic report(input int tn, input string name);
    $display("Test %0d %-12s %s: %0d checks, %0d errors", tn + 1, name,
             (err[tn] == 0) ? "PASS" : "FAIL", chk[tn], err[tn]);
  endtask

  task automatic finish_tests();
    int total_chk;
    int total_err;
    total_chk = 0;
    total_err = 0;
    // Nothing lost, nothing extra
    chk[4]++;
    if (store_cnt != exp_total || exp_addr.size() != 0) begin
      err[4]++;
      $display("Saw %0d stores but the program holds %0d", store_cnt, exp_total);
    end
    report(1, "fetch order");
    report(2, "stores");
    report(3, "forwarding");
    report(4, "store order");
    report(5, "sleep");
    for (int i = 0; i < 6; i++) begin
      total_chk += chk[i];
      total_err += err[i];
    end
    $display("Checks: %0d, errors: %0d", total_chk, total_err);
    error_cnt_o = total_err;
    done_o      = 1'b1;
  endtask

  ////////////////////////////////////////////////////
  // Sampling, settled before the next rising edge
  ////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    #10;
    if (!arst_n_i) begin
      done_o      = 1'b0;
      error_cnt_o = 0;
      model_ready = 1'b0;
      en_seen     = 1'b0;
      slept       = 1'b0;
      off_cycles  = 0;
      store_cnt   = 0;
      for (int i = 0; i < 6; i++) begin
        chk[i] = 0;
        err[i] = 0;
      end
    end else if (done_o !== 1'b1) begin
      // Whole program run once, in address order
      if (!model_ready) begin
        for (int i = 0; i < 32; i++) begin
          regs[i] = 32'h0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
          exec_word(prog_i[i], i);
        end
        exp_total   = exp_addr.size();
        exp_pc      = boot_addr_i;
        model_ready = 1'b1;
      end
      if (!en_seen && !fetch_enable_i) begin
        compare(0, "instr_req_o", {31'b0, instr_req_i}, 32'h0);
        compare(0, "data_req_o", {31'b0, data_req_i}, 32'h0);
        compare(0, "core_sleep_o", {31'b0, core_sleep_i}, 32'h1);
      end
      if (!en_seen && fetch_enable_i) begin
        en_seen = 1'b1;
        report(0, "reset idle");
      end
      if (instr_req_i && instr_gnt_i) begin
        compare(1, "instr_addr_o", instr_addr_i, exp_pc);
        exp_pc = exp_pc + 32'd4;
      end
      if (data_req_i && data_gnt_i) begin
        store_cnt++;
        chk[4]++;
        if (exp_addr.size() == 0) begin
          err[4]++;
          $display("Store to 0x%08h at %0t ns has no store left in the program",
                   data_addr_i, $time);
        end else begin
          t = (exp_idx[0] < PREFIX_LEN) ? 3 : 2;
          compare(t, "data_addr_o", data_addr_i, exp_addr.pop_front());
          compare(t, "data_wdata_o", data_wdata_i, exp_data.pop_front());
          void'(exp_idx.pop_front());
        end
      end
      // Drain after fetch is switched off
      if (en_seen && !fetch_enable_i) begin
        off_cycles++;
        compare(5, "instr_req_o", {31'b0, instr_req_i}, 32'h0);
        if (core_sleep_i) begin
          slept = 1'b1;
        end
        // Sleep means every stage is empty, or give up after 20 cycles
        if (slept || off_cycles == 20) begin
          chk[5]++;
          if (!slept) begin
            err[5]++;
            $display("core_sleep_o did not rise within 20 cycles of fetch disable");
          end
          finish_tests();
        end
      end
    end
  end

endmodule

/* tb_core.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module tb_core;

  localparam int PROG_LEN   = 200;
  // Dependent words at the start of the program
  localparam int PREFIX_LEN = 8;
  // Fetch, store wait and grant delay per word, plus margin
  localparam int CYCLE_LIMIT = PROG_LEN * (4 + 3 + 3) + 500;

  logic        clk_i;
  logic        arst_n_i;
  logic        fetch_enable_i;
  logic [31:0] boot_addr_i;
  logic        instr_req_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  logic [31:0] instr_addr_o;
  logic [31:0] instr_rdata_i;
  logic        data_req_o;
  logic        data_gnt_i;
  logic [31:0] data_addr_o;
  logic [31:0] data_wdata_o;
  logic        core_sleep_o;

  logic [31:0] prog [PROG_LEN];
  integer      seed;
  int          cycle_cnt;
  // Bus responder state, sampled mid-cycle
  logic        ifetch_acc;
  logic [31:0] ifetch_addr;
  logic        ireq_seen;
  int          igwait;
  logic        dacc;
  logic        dreq_seen;
  int          dgwait;
  logic        past_end;
  logic        chk_done;
  int          chk_errors;

  rv_core dut0 (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .core_sleep_o   ( core_sleep_o   ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .data_req_o     ( data_req_o     ),
    .data_gnt_i     ( data_gnt_i     ),
    .data_addr_o    ( data_addr_o    ),
    .data_wdata_o   ( data_wdata_o   )
  );

  tb_checker #(
    .PROG_LEN   ( PROG_LEN   ),
    .PREFIX_LEN ( PREFIX_LEN )
  ) monitor0 (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_i    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_addr_i   ( instr_addr_o   ),
    .data_req_i     ( data_req_o     ),
    .data_gnt_i     ( data_gnt_i     ),
    .data_addr_i    ( data_addr_o    ),
    .data_wdata_i   ( data_wdata_o   ),
    .core_sleep_i   ( core_sleep_o   ),
    .prog_i         ( prog           ),
    .done_o         ( chk_done       ),
    .error_cnt_o    ( chk_errors     )
  );

  always #50 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Instruction encoders
  //////////////////////////////////////////////////

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, `RV_OPC_OP_IMM};
  endfunction

  // SW only
  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, `RV_OPC_LUI};
  endfunction

  // Program words, ADDI x0,x0,0 elsewhere
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - boot_addr_i;
    if (offset < 32'(PROG_LEN * 4)) begin
      return prog[int'(offset >> 2)];
    end
    return 32'h0000_0013;
  endfunction

  task automatic build_program();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    r1 = $random(seed);
    boot_addr_i = {16'h0001, r1[15:2], 2'b00};
    // Chain, each word reads the one before
    prog[0] = enc_u(20'h8badf, 5'd1);
    prog[1] = enc_i(12'h35a, 5'd1, 3'd0, 5'd2);
    prog[2] = enc_r(7'b0000000, 5'd1, 5'd2, 3'd4, 5'd3);
    prog[3] = enc_i({7'b0000000, 5'd7}, 5'd3, 3'd1, 5'd4);
    prog[4] = enc_s(12'h008, 5'd4, 5'd3);
    prog[5] = enc_r(7'b0100000, 5'd2, 5'd4, 3'd0, 5'd5);
    prog[6] = enc_i({7'b0100000, 5'd3}, 5'd5, 3'd5, 5'd6);
    prog[7] = enc_s(12'hffc, 5'd6, 5'd5);
    for (int i = PREFIX_LEN; i < PROG_LEN; i++) begin
      r1 = $random(seed);
      r2 = $random(seed);
      f3 = r1[17:15];
      // Alternate funct7 only where SUB and SRA exist
      f7 = (r1[18] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'b0000000;
      imm = r2[11:0];
      if (f3 == 3'd1) begin
        imm = {7'b0000000, r2[4:0]};
      end else if (f3 == 3'd5) begin
        imm = {f7, r2[4:0]};
      end
      if (r2[13:12] == 2'b00) begin
        prog[i] = enc_s(r2[11:0], r1[14:10], r1[9:5]);
      end else begin
        case (r2[15:14])
          2'b00:   prog[i] = enc_r(f7, r1[14:10], r1[9:5], f3, r1[4:0]);
          2'b10:   prog[i] = enc_u(r2[31:12], r1[4:0]);
          default: prog[i] = enc_i(imm, r1[9:5], f3, r1[4:0]);
        endcase
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Bus responders
  //////////////////////////////////////////////////

  // Drive on the falling edge, sample once settled
  always @(negedge clk_i) begin
    instr_rvalid_i = ifetch_acc;
    instr_rdata_i  = ifetch_acc ? word_at(ifetch_addr) : 32'h0;
    if (ifetch_acc) begin
      igwait = $unsigned($random(seed)) % 4;
      // Prefix granted at once so its words reach decode back to back
      if ((ifetch_addr - boot_addr_i) < 32'(PREFIX_LEN * 4)) begin
        igwait = 0;
      end
    end else if (ireq_seen && igwait != 0) begin
      igwait = igwait - 1;
    end
    instr_gnt_i = (igwait == 0);
    if (dacc) begin
      dgwait = $unsigned($random(seed)) % 4;
    end else if (dreq_seen && dgwait != 0) begin
      dgwait = dgwait - 1;
    end
    data_gnt_i = (dgwait == 0);
    #10;
    ifetch_acc  = instr_req_o && instr_gnt_i;
    ifetch_addr = instr_addr_o;
    ireq_seen   = instr_req_o;
    dacc        = data_req_o && data_gnt_i;
    dreq_seen   = data_req_o;
    if (ifetch_acc && (instr_addr_o - boot_addr_i) >= 32'(PROG_LEN * 4)) begin
      past_end = 1'b1;
    end
    cycle_cnt = cycle_cnt + 1;
  end

  initial begin
    seed           = 32'h79e270db;
    clk_i          = 1'b0;
    arst_n_i       = 1'b0;
    fetch_enable_i = 1'b0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = 32'h0;
    data_gnt_i     = 1'b0;
    ifetch_acc     = 1'b0;
    ifetch_addr    = 32'h0;
    ireq_seen      = 1'b0;
    igwait         = 0;
    dacc           = 1'b0;
    dreq_seen      = 1'b0;
    dgwait         = 0;
    past_end       = 1'b0;
    cycle_cnt      = 0;
    build_program();
    repeat (8) @(negedge clk_i);
    arst_n_i = 1'b1;
    // Idle window before fetch starts
    repeat (4) @(negedge clk_i);
    fetch_enable_i = 1'b1;
    while (!past_end && cycle_cnt < CYCLE_LIMIT) @(negedge clk_i);
    fetch_enable_i = 1'b0;
    while (chk_done !== 1'b1 && cycle_cnt < CYCLE_LIMIT) @(negedge clk_i);
    if (chk_done === 1'b1 && chk_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      if (chk_done !== 1'b1) begin
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      end
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+.
rv_pkg.sv
rv_register_file.sv
rv_if_stage.sv
rv_id_stage.sv
rv_ex_stage.sv
rv_core.sv
tb_checker.sv
tb_core.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_core \
  -Mdir obj_dir -o tb_core
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
  exit 0
fi
exit 1
